//--- project.f
src/id_pkg.sv
src/id_inst_decode.sv
src/id_operand_sel.sv
src/id_branch_unit.sv
src/id_stage_reg.sv
src/id_stage.sv
test/tb_id_stage.sv

//--- Makefile
VERILATOR ?= verilator
FILELIST  ?= project.f
TB_TOP    ?= tb_id_stage
RTL_TOP   ?= id_stage
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall

SRCS := $(shell grep -v '^+' $(FILELIST))
RTL  := $(filter src/%,$(SRCS))

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TB_TOP)

$(OBJ_DIR)/V$(TB_TOP): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TB_TOP) | tee $(LOG)
	grep -q "^TEST PASS$$" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) $(RTL) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- test/tb_id_stage.sv
`timescale 1ns/1ps

module tb_id_stage;
	import id_pkg::*;

	localparam int CLK_P = 40;

	// registered EX-bound values
	typedef struct packed {
		logic [XLEN-1:0]   pc;
		logic [XLEN-1:0]   opr1;
		logic [XLEN-1:0]   opr2;
		logic [XLEN-1:0]   offset;
		logic [XLEN-1:0]   rtvalue;
		logic [REG_AW-1:0] waddr;
		logic [WREN_W-1:0] wren;
		logic [AOP_W-1:0]  aluop;
		logic [MMOP_W-1:0] memop;
		logic [EXC_W-1:0]  excs;
		logic              has_exc;
		logic              inslot;
		logic              nofwd;
		logic              ov_inst;
	} stage_t;

	// same-cycle outputs
	typedef struct packed {
		logic              act;
		logic              br_en;
		logic              chk_pc;
		logic [XLEN-1:0]   br_pc;
		logic              slot;
		logic              is_br;
		logic              ren1;
		logic              ren2;
		logic [REG_AW-1:0] ra1;
		logic [REG_AW-1:0] ra2;
	} comb_t;

	logic clk, arst_n_i, id_flush_i, id_stall_i;
	logic [XLEN-1:0] id_pc_i, id_inst_i, id_reg1data_i, id_reg2data_i;
	logic [XLEN-1:0] raw_data1_i, raw_data2_i, id_res_from_ex_i;
	logic [EXC_W-1:0] id_excs_i;
	logic id_inslot_i, id_has_exc_i, id_ex_res_as1_i, id_ex_res_as2_i;
	logic id_branch_en_o, id_next_inslot_o, id_is_branch_o, id_ren1_o, id_ren2_o;
	logic [XLEN-1:0] id_branch_pc_o, id_pc_o, id_opr1_o, id_opr2_o, id_offset_o, id_rtvalue_o;
	logic [REG_AW-1:0] id_reg1addr_o, id_reg2addr_o, id_waddr_o;
	logic [WREN_W-1:0] id_wren_o;
	logic [AOP_W-1:0] id_aluop_o;
	logic [MMOP_W-1:0] id_memop_o;
	logic [EXC_W-1:0] id_excs_o;
	logic id_has_exc_o, id_inslot_o, id_nofwd_o, id_ov_inst_o;

	// stimulus for the next apply
	logic [XLEN-1:0] v_inst, v_pc, v_r1, v_r2, v_raw1, v_raw2, v_exr;
	logic [EXC_W-1:0] v_fexc;
	logic v_as1, v_as2, v_slot, v_fhas, v_stall, v_flush;

	stage_t nx, pend, mdl;
	comb_t  cx, cpend;
	logic [31:0] lfsr;
	int errors, checks, tests;

	id_stage dut_i (.*);

	initial begin
		clk = 1'b0;
		forever begin
			#(CLK_P / 2) clk = ~clk;
		end
	end

	initial begin
		#(CLK_P * 3000);
		$display("timeout: the run did not reach its end");
		$display("TEST FAIL");
		$finish;
	end

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_bits(input int n);
		logic [31:0] r;
		logic fb;
		r = '0;
		for (int k = 0; k < n; k++) begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			r = {r[30:0], fb};
		end
		return r;
	endfunction

	function automatic logic [4:0] reg_idx();
		logic [31:0] r;
		r = lfsr_bits(5);
		return r[4:0];
	endfunction

	function automatic logic [15:0] imm16();
		logic [31:0] r;
		r = lfsr_bits(16);
		return r[15:0];
	endfunction

	function automatic logic [31:0] r_word(input logic [4:0] rs, input logic [4:0] rt,
	                                       input logic [4:0] rd, input logic [4:0] sa,
	                                       input logic [5:0] fn);
		return {OP_SPECIAL, rs, rt, rd, sa, fn};
	endfunction

	function automatic logic [31:0] i_word(input logic [5:0] op, input logic [4:0] rs,
	                                       input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
	                           input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("FAIL %s got %h exp %h", name, got, exp);
		end
	endtask

	task automatic wait_cycles(input int n);
		for (int k = 0; k < n; k++) begin
			@(posedge clk);
		end
	endtask

	task automatic wait_release();
		int n;
		n = 0;
		while (arst_n_i !== 1'b1 && n < 50) begin
			@(posedge clk);
			n++;
		end
		if (arst_n_i !== 1'b1) begin
			errors++;
			$display("reset was not released within 50 cycles");
		end
	endtask

	task automatic finish_test(input string name, input int e0);
		tests++;
		$display("test %-26s %s", name, (errors == e0) ? "ok" : "has errors");
	endtask

	// random data, default expectation for an instruction with no effect
	task automatic prep(input logic [31:0] inst);
		v_inst = inst;
		v_pc = lfsr_bits(30) << 2;
		v_r1 = lfsr_bits(32);
		v_r2 = lfsr_bits(32);
		v_raw1 = lfsr_bits(32);
		v_raw2 = lfsr_bits(32);
		v_exr = lfsr_bits(32);
		v_slot = (lfsr_bits(1) != 0);
		v_as1 = 1'b0;
		v_as2 = 1'b0;
		v_fhas = 1'b0;
		v_fexc = '0;
		nx = '0;
		nx.pc = v_pc;
		nx.opr1 = v_r1;
		nx.opr2 = v_r2;
		nx.offset = {{16{inst[15]}}, inst[15:0]};
		nx.rtvalue = v_r2;
		nx.waddr = inst[15:11];
		nx.inslot = v_slot;
		cx = '0;
		cx.act = 1'b1;
		cx.ra1 = inst[25:21];
		cx.ra2 = inst[20:16];
	endtask

	task automatic apply();
		@(posedge clk);
		id_inst_i <= v_inst;
		id_pc_i <= v_pc;
		id_reg1data_i <= v_r1;
		id_reg2data_i <= v_r2;
		raw_data1_i <= v_raw1;
		raw_data2_i <= v_raw2;
		id_res_from_ex_i <= v_exr;
		id_ex_res_as1_i <= v_as1;
		id_ex_res_as2_i <= v_as2;
		id_inslot_i <= v_slot;
		id_has_exc_i <= v_fhas;
		id_excs_i <= v_fexc;
		id_stall_i <= v_stall;
		id_flush_i <= v_flush;
		pend <= nx;
		cpend <= cx;
	endtask

	// hold on stall, clear on flush
	always @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			mdl <= '0;
		end else if (!id_stall_i) begin
			mdl <= id_flush_i ? '0 : pend;
		end
	end

	always @(negedge clk) begin
		if (arst_n_i) begin
			check_value("id_pc_o", id_pc_o, mdl.pc);
			check_value("id_opr1_o", id_opr1_o, mdl.opr1);
			check_value("id_opr2_o", id_opr2_o, mdl.opr2);
			check_value("id_offset_o", id_offset_o, mdl.offset);
			check_value("id_rtvalue_o", id_rtvalue_o, mdl.rtvalue);
			check_value("id_waddr_o", 32'(id_waddr_o), 32'(mdl.waddr));
			check_value("id_wren_o", 32'(id_wren_o), 32'(mdl.wren));
			check_value("id_aluop_o", 32'(id_aluop_o), 32'(mdl.aluop));
			check_value("id_memop_o", 32'(id_memop_o), 32'(mdl.memop));
			check_value("id_excs_o", 32'(id_excs_o), 32'(mdl.excs));
			check_value("id_has_exc_o", 32'(id_has_exc_o), 32'(mdl.has_exc));
			check_value("id_inslot_o", 32'(id_inslot_o), 32'(mdl.inslot));
			check_value("id_nofwd_o", 32'(id_nofwd_o), 32'(mdl.nofwd));
			check_value("id_ov_inst_o", 32'(id_ov_inst_o), 32'(mdl.ov_inst));
			if (cpend.act) begin
				check_value("id_branch_en_o", 32'(id_branch_en_o), 32'(cpend.br_en));
				check_value("id_next_inslot_o", 32'(id_next_inslot_o), 32'(cpend.slot));
				check_value("id_is_branch_o", 32'(id_is_branch_o), 32'(cpend.is_br));
				check_value("id_ren1_o", 32'(id_ren1_o), 32'(cpend.ren1));
				check_value("id_ren2_o", 32'(id_ren2_o), 32'(cpend.ren2));
				check_value("id_reg1addr_o", 32'(id_reg1addr_o), 32'(cpend.ra1));
				check_value("id_reg2addr_o", 32'(id_reg2addr_o), 32'(cpend.ra2));
				if (cpend.chk_pc) begin
					check_value("id_branch_pc_o", id_branch_pc_o, cpend.br_pc);
				end
			end
		end
	end

	task automatic addu_case();
		prep(r_word(reg_idx(), reg_idx(), reg_idx(), 5'd0, FN_ADDU));
		nx.aluop[AOP_ADD] = 1'b1;
		nx.wren = '1;
		cx.ren1 = 1'b1;
		cx.ren2 = 1'b1;
		apply();
	endtask

	task automatic alu_decode();
		logic [4:0] rt, sa;
		logic [15:0] imm;
		int e0;
		e0 = errors;
		addu_case();
		rt = reg_idx();
		imm = imm16();
		prep(i_word(OP_ADDIU, reg_idx(), rt, imm));
		nx.aluop[AOP_ADD] = 1'b1;
		nx.wren = '1;
		nx.opr2 = {{16{imm[15]}}, imm};
		nx.waddr = rt;
		cx.ren1 = 1'b1;
		apply();
		imm = imm16();
		prep(i_word(OP_ORI, reg_idx(), rt, imm));
		nx.aluop[AOP_OR] = 1'b1;
		nx.wren = '1;
		nx.opr2 = {16'h0, imm}; // zero extended
		nx.waddr = rt;
		cx.ren1 = 1'b1;
		apply();
		sa = reg_idx();
		prep(r_word(5'd0, reg_idx(), reg_idx(), sa, FN_SLL));
		nx.aluop[AOP_SLL] = 1'b1;
		nx.wren = '1;
		nx.opr1 = {27'h0, sa};
		cx.ren2 = 1'b1;
		apply();
		prep(r_word(reg_idx(), reg_idx(), reg_idx(), 5'd0, FN_ADD));
		nx.aluop[AOP_ADD] = 1'b1;
		nx.wren = '1;
		nx.ov_inst = 1'b1;
		cx.ren1 = 1'b1;
		cx.ren2 = 1'b1;
		apply();
		wait_cycles(2);
		finish_test("alu and immediate decode", e0);
	endtask

	task automatic mem_decode();
		logic [4:0] rt;
		logic [15:0] imm;
		int e0;
		e0 = errors;
		rt = reg_idx();
		imm = imm16();
		prep(i_word(OP_LW, reg_idx(), rt, imm));
		nx.aluop[AOP_ADD] = 1'b1;
		nx.memop[MMOP_LW] = 1'b1;
		nx.nofwd = 1'b1;
		nx.wren = '1;
		nx.waddr = rt;
		nx.opr2 = {{16{imm[15]}}, imm};
		cx.ren1 = 1'b1;
		apply();
		imm = imm16();
		prep(i_word(OP_SW, reg_idx(), reg_idx(), imm));
		nx.aluop[AOP_ADD] = 1'b1;
		nx.memop[MMOP_SW] = 1'b1;
		nx.nofwd = 1'b1; // no write back
		nx.opr2 = {{16{imm[15]}}, imm};
		cx.ren1 = 1'b1;
		cx.ren2 = 1'b1;
		apply();
		wait_cycles(2);
		finish_test("loads and stores", e0);
	endtask

	task automatic beq_case(input logic as1, input logic as2, input logic equal);
		logic [15:0] imm;
		imm = imm16();
		prep(i_word(OP_BEQ, reg_idx(), reg_idx(), imm));
		v_as1 = as1;
		v_as2 = as2;
		if (as2) begin
			v_exr = equal ? v_raw1 : ~v_raw1;
		end else if (as1) begin
			v_raw2 = equal ? v_exr : ~v_exr;
		end else begin
			v_raw2 = equal ? v_raw1 : ~v_raw1;
		end
		cx.br_en = equal;
		cx.chk_pc = 1'b1;
		cx.br_pc = v_pc + 32'd4 + {{14{imm[15]}}, imm, 2'b00};
		cx.slot = 1'b1;
		cx.is_br = 1'b1;
		cx.ren1 = 1'b1;
		cx.ren2 = 1'b1;
		apply();
	endtask

	task automatic branch_resolve();
		logic [31:0] r;
		logic [XLEN-1:0] pcp4;
		int e0;
		e0 = errors;
		beq_case(1'b0, 1'b0, 1'b1);
		beq_case(1'b0, 1'b0, 1'b0);
		beq_case(1'b1, 1'b0, 1'b1);
		beq_case(1'b0, 1'b1, 1'b0);
		beq_case(1'b0, 1'b1, 1'b1);
		for (int k = 0; k < 2; k++) begin
			r = lfsr_bits(26);
			prep({(k == 0) ? OP_J : OP_JAL, r[25:0]});
			pcp4 = v_pc + 32'd4;
			cx.br_en = 1'b1;
			cx.chk_pc = 1'b1;
			cx.br_pc = {pcp4[31:28], r[25:0], 2'b00};
			cx.slot = 1'b1;
			if (k == 1) begin // jal links through r31
				nx.aluop[AOP_ADD] = 1'b1;
				nx.wren = '1;
				nx.waddr = 5'd31;
				nx.opr1 = v_pc;
				nx.opr2 = 32'd8;
			end
			apply();
		end
		wait_cycles(2);
		finish_test("branches and jumps", e0);
	endtask

	task automatic exc_case(input logic [31:0] inst, input int bitpos);
		logic [31:0] r;
		prep(inst);
		r = lfsr_bits(EXC_W);
		v_fhas = 1'b1;
		v_fexc = r[EXC_W-1:0];
		nx.excs[4:1] = r[4:1]; // bit 0 stays clear
		nx.excs[bitpos] = 1'b1;
		nx.has_exc = 1'b1;
		apply();
	endtask

	task automatic exc_flags();
		logic [31:0] r;
		int e0;
		e0 = errors;
		exc_case(r_word(5'd0, 5'd0, 5'd0, 5'd0, FN_SYSCALL), EXC_SYS);
		exc_case(r_word(5'd0, 5'd0, 5'd0, 5'd0, FN_BREAK), EXC_BRK);
		r = lfsr_bits(26);
		exc_case({6'h3f, r[25:0]}, EXC_RI);
		exc_case(32'h4200_0018, EXC_ERET);
		wait_cycles(2);
		finish_test("exceptions", e0);
	endtask

	task automatic stall_flush();
		int e0;
		e0 = errors;
		addu_case();
		v_stall = 1'b1;
		addu_case();
		addu_case();
		v_stall = 1'b0;
		v_flush = 1'b1;
		addu_case();
		v_flush = 1'b0;
		addu_case();
		wait_cycles(2);
		finish_test("stall and flush", e0);
	endtask

	initial begin
		lfsr = 32'd90075;
		errors = 0;
		checks = 0;
		tests = 0;
		arst_n_i = 1'b0;
		id_stall_i = 1'b1; // keep zeros in the stage until the first apply
		id_flush_i = 1'b0;
		id_pc_i = '0;
		id_inst_i = '0;
		id_inslot_i = 1'b0;
		id_excs_i = '0;
		id_has_exc_i = 1'b0;
		id_reg1data_i = '0;
		id_reg2data_i = '0;
		raw_data1_i = '0;
		raw_data2_i = '0;
		id_res_from_ex_i = '0;
		id_ex_res_as1_i = 1'b0;
		id_ex_res_as2_i = 1'b0;
		pend = '0;
		cpend = '0;
		v_stall = 1'b0;
		v_flush = 1'b0;
		wait_cycles(16);
		arst_n_i <= 1'b1;
		wait_release();
		wait_cycles(2);
		finish_test("reset", 0);
		alu_decode();
		mem_decode();
		branch_resolve();
		exc_flags();
		stall_flush();
		$display("tests %0d  checks %0d  errors %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

//--- src/id_stage.sv
`timescale 1ns/1ps

module id_stage (
	input  logic                         clk,
	input  logic                         arst_n_i,
	input  logic                         id_flush_i,
	input  logic                         id_stall_i,
	// from fetch
	input  logic [id_pkg::XLEN-1:0]      id_pc_i,
	input  logic [id_pkg::XLEN-1:0]      id_inst_i,
	input  logic                         id_inslot_i,
	input  logic [id_pkg::EXC_W-1:0]     id_excs_i,
	input  logic                         id_has_exc_i,
	// regfile and bypass
	input  logic [id_pkg::XLEN-1:0]      id_reg1data_i,
	input  logic [id_pkg::XLEN-1:0]      id_reg2data_i,
	input  logic [id_pkg::XLEN-1:0]      raw_data1_i,
	input  logic [id_pkg::XLEN-1:0]      raw_data2_i,
	input  logic [id_pkg::XLEN-1:0]      id_res_from_ex_i,
	input  logic                         id_ex_res_as1_i,
	input  logic                         id_ex_res_as2_i,
	// branch, same cycle
	output logic                         id_branch_en_o,
	output logic [id_pkg::XLEN-1:0]      id_branch_pc_o,
	output logic                         id_next_inslot_o,
	output logic                         id_is_branch_o,
	output logic                         id_ren1_o,
	output logic                         id_ren2_o,
	output logic [id_pkg::REG_AW-1:0]    id_reg1addr_o,
	output logic [id_pkg::REG_AW-1:0]    id_reg2addr_o,
	// to EX
	output logic [id_pkg::XLEN-1:0]      id_pc_o,
	output logic [id_pkg::XLEN-1:0]      id_opr1_o,
	output logic [id_pkg::XLEN-1:0]      id_opr2_o,
	output logic [id_pkg::XLEN-1:0]      id_offset_o,
	output logic [id_pkg::XLEN-1:0]      id_rtvalue_o,
	output logic [id_pkg::REG_AW-1:0]    id_waddr_o,
	output logic [id_pkg::WREN_W-1:0]    id_wren_o,
	output logic [id_pkg::AOP_W-1:0]     id_aluop_o,
	output logic [id_pkg::MMOP_W-1:0]    id_memop_o,
	output logic [id_pkg::EXC_W-1:0]     id_excs_o,
	output logic                         id_has_exc_o,
	output logic                         id_inslot_o,
	output logic                         id_nofwd_o,
	output logic                         id_ov_inst_o
);
	import id_pkg::*;

	mips_inst_u         inst;
	logic [AOP_W-1:0]   alu_op;
	logic [MMOP_W-1:0]  mem_op;
	logic [SEL_W-1:0]   src1_sel, src2_sel, wa_sel;
	logic [BR_W-1:0]    br_kind;
	logic               wren, nofwd, ov_inst;
	logic               exc_sys, exc_brk, exc_ri, exc_eret;
	logic [XLEN-1:0]    opr1, opr2, offset;
	logic [REG_AW-1:0]  waddr;
	logic [EXC_W-1:0]   excs;

	assign inst   = id_inst_i;
	assign offset = {{(XLEN-16){inst.i.imm[15]}}, inst.i.imm};

	always_comb begin
		excs = '0;
		excs[EXC_SYS-1:1] = id_has_exc_i ? id_excs_i[EXC_SYS-1:1] : '0; // fetch side
		excs[EXC_SYS]     = exc_sys;
		excs[EXC_BRK]     = exc_brk;
		excs[EXC_RI]      = exc_ri;
		excs[EXC_ERET]    = exc_eret;
	end

	id_inst_decode u_decode (
		.inst_i(inst), .ren1_o(id_ren1_o), .ren2_o(id_ren2_o),
		.reg1addr_o(id_reg1addr_o), .reg2addr_o(id_reg2addr_o),
		.alu_op_o(alu_op), .mem_op_o(mem_op),
		.src1_sel_o(src1_sel), .src2_sel_o(src2_sel), .wa_sel_o(wa_sel),
		.wren_o(wren), .nofwd_o(nofwd), .ov_inst_o(ov_inst), .br_kind_o(br_kind),
		.exc_sys_o(exc_sys), .exc_brk_o(exc_brk), .exc_ri_o(exc_ri), .exc_eret_o(exc_eret)
	);

	id_operand_sel u_opsel (
		.inst_i(inst), .pc_i(id_pc_i), .reg1data_i(id_reg1data_i), .reg2data_i(id_reg2data_i),
		.src1_sel_i(src1_sel), .src2_sel_i(src2_sel), .wa_sel_i(wa_sel),
		.opr1_o(opr1), .opr2_o(opr2), .waddr_o(waddr)
	);

	id_branch_unit u_branch (
		.inst_i(inst), .pc_i(id_pc_i), .br_kind_i(br_kind),
		.raw_data1_i(raw_data1_i), .raw_data2_i(raw_data2_i), .ex_res_i(id_res_from_ex_i),
		.ex_res_as1_i(id_ex_res_as1_i), .ex_res_as2_i(id_ex_res_as2_i),
		.branch_en_o(id_branch_en_o), .branch_pc_o(id_branch_pc_o),
		.next_inslot_o(id_next_inslot_o), .is_branch_o(id_is_branch_o)
	);

	id_stage_reg u_sreg (
		.clk(clk), .arst_n_i(arst_n_i), .stall_i(id_stall_i), .flush_i(id_flush_i),
		.pc_d_i(id_pc_i), .opr1_d_i(opr1), .opr2_d_i(opr2), .offset_d_i(offset),
		.rtvalue_d_i(id_reg2data_i), .waddr_d_i(waddr), .wren_d_i(wren),
		.aluop_d_i(alu_op), .memop_d_i(mem_op), .excs_d_i(excs),
		.inslot_d_i(id_inslot_i), .nofwd_d_i(nofwd), .ov_inst_d_i(ov_inst),
		.pc_o(id_pc_o), .opr1_o(id_opr1_o), .opr2_o(id_opr2_o), .offset_o(id_offset_o),
		.rtvalue_o(id_rtvalue_o), .waddr_o(id_waddr_o), .wren_o(id_wren_o),
		.aluop_o(id_aluop_o), .memop_o(id_memop_o), .excs_o(id_excs_o),
		.has_exc_o(id_has_exc_o), .inslot_o(id_inslot_o), .nofwd_o(id_nofwd_o),
		.ov_inst_o(id_ov_inst_o)
	);

endmodule

//--- src/id_stage_reg.sv
`timescale 1ns/1ps

module id_stage_reg (
	input  logic                         clk,
	input  logic                         arst_n_i,
	input  logic                         stall_i,
	input  logic                         flush_i,
	input  logic [id_pkg::XLEN-1:0]      pc_d_i,
	input  logic [id_pkg::XLEN-1:0]      opr1_d_i,
	input  logic [id_pkg::XLEN-1:0]      opr2_d_i,
	input  logic [id_pkg::XLEN-1:0]      offset_d_i,
	input  logic [id_pkg::XLEN-1:0]      rtvalue_d_i,
	input  logic [id_pkg::REG_AW-1:0]    waddr_d_i,
	input  logic                         wren_d_i,
	input  logic [id_pkg::AOP_W-1:0]     aluop_d_i,
	input  logic [id_pkg::MMOP_W-1:0]    memop_d_i,
	input  logic [id_pkg::EXC_W-1:0]     excs_d_i,
	input  logic                         inslot_d_i,
	input  logic                         nofwd_d_i,
	input  logic                         ov_inst_d_i,
	output logic [id_pkg::XLEN-1:0]      pc_o,
	output logic [id_pkg::XLEN-1:0]      opr1_o,
	output logic [id_pkg::XLEN-1:0]      opr2_o,
	output logic [id_pkg::XLEN-1:0]      offset_o,
	output logic [id_pkg::XLEN-1:0]      rtvalue_o,
	output logic [id_pkg::REG_AW-1:0]    waddr_o,
	output logic [id_pkg::WREN_W-1:0]    wren_o,
	output logic [id_pkg::AOP_W-1:0]     aluop_o,
	output logic [id_pkg::MMOP_W-1:0]    memop_o,
	output logic [id_pkg::EXC_W-1:0]     excs_o,
	output logic                         has_exc_o,
	output logic                         inslot_o,
	output logic                         nofwd_o,
	output logic                         ov_inst_o
);
	import id_pkg::*;

	// whole stage as one word, wren kept as a single bit
	logic [5*XLEN+REG_AW+AOP_W+MMOP_W+EXC_W+4:0] d, q;
	logic                                        wren_q;

	assign d = {pc_d_i, opr1_d_i, opr2_d_i, offset_d_i, rtvalue_d_i, waddr_d_i, wren_d_i,
	            aluop_d_i, memop_d_i, excs_d_i, |excs_d_i, inslot_d_i, nofwd_d_i, ov_inst_d_i};

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			q <= '0;
		end else if (!stall_i) begin
			q <= flush_i ? '0 : d; // flush wins when not stalled
		end
	end

	assign {pc_o, opr1_o, opr2_o, offset_o, rtvalue_o, waddr_o, wren_q,
	        aluop_o, memop_o, excs_o, has_exc_o, inslot_o, nofwd_o, ov_inst_o} = q;

	assign wren_o = {WREN_W{wren_q}}; // full word writes only

endmodule

//--- src/id_branch_unit.sv
`timescale 1ns/1ps

module id_branch_unit (
	input  id_pkg::mips_inst_u          inst_i,
	input  logic [id_pkg::XLEN-1:0]     pc_i,
	input  logic [id_pkg::BR_W-1:0]     br_kind_i,
	input  logic [id_pkg::XLEN-1:0]     raw_data1_i,
	input  logic [id_pkg::XLEN-1:0]     raw_data2_i,
	input  logic [id_pkg::XLEN-1:0]     ex_res_i,
	input  logic                        ex_res_as1_i,
	input  logic                        ex_res_as2_i,
	output logic                        branch_en_o,
	output logic [id_pkg::XLEN-1:0]     branch_pc_o,
	output logic                        next_inslot_o,
	output logic                        is_branch_o
);
	import id_pkg::*;

	logic [XLEN-1:0] op1, op2;
	logic [XLEN-1:0] pcp4, b_target, j_target;
	logic            eq, lz, lez;

	// EX result bypass
	assign op1 = ex_res_as1_i ? ex_res_i : raw_data1_i;
	assign op2 = ex_res_as2_i ? ex_res_i : raw_data2_i;

	assign eq  = (op1 == op2);
	assign lz  = op1[XLEN-1];
	assign lez = lz | (op1 == '0);

	assign pcp4     = pc_i + XLEN'(4);
	assign b_target = pcp4 + {{(XLEN-18){inst_i.i.imm[15]}}, inst_i.i.imm, 2'b00};
	assign j_target = {pcp4[XLEN-1:28], inst_i.j.target, 2'b00}; // 256MB region of slot

	always_comb begin
		case (br_kind_i)
			BR_BEQ:      branch_en_o = eq;
			BR_BNE:      branch_en_o = ~eq;
			BR_BGEZ:     branch_en_o = ~lz;
			BR_BGTZ:     branch_en_o = ~lez;
			BR_BLEZ:     branch_en_o = lez;
			BR_BLTZ:     branch_en_o = lz;
			BR_J, BR_JR: branch_en_o = 1'b1;
			default:     branch_en_o = 1'b0;
		endcase

		case (br_kind_i)
			BR_J:    branch_pc_o = j_target;
			BR_JR:   branch_pc_o = op1;
			default: branch_pc_o = b_target;
		endcase
	end

	assign next_inslot_o = (br_kind_i != BR_NONE); // next fetch is the delay slot
	// j and jal need no operands, so they skip the bypass path
	assign is_branch_o   = next_inslot_o & (br_kind_i != BR_J);

endmodule

//--- src/id_operand_sel.sv
`timescale 1ns/1ps

module id_operand_sel (
	input  id_pkg::mips_inst_u          inst_i,
	input  logic [id_pkg::XLEN-1:0]     pc_i,
	input  logic [id_pkg::XLEN-1:0]     reg1data_i,
	input  logic [id_pkg::XLEN-1:0]     reg2data_i,
	input  logic [id_pkg::SEL_W-1:0]    src1_sel_i,
	input  logic [id_pkg::SEL_W-1:0]    src2_sel_i,
	input  logic [id_pkg::SEL_W-1:0]    wa_sel_i,
	output logic [id_pkg::XLEN-1:0]     opr1_o,
	output logic [id_pkg::XLEN-1:0]     opr2_o,
	output logic [id_pkg::REG_AW-1:0]   waddr_o
);
	import id_pkg::*;

	logic [XLEN-1:0] imm_sext;
	logic [XLEN-1:0] imm_zext; // also used by lui, shifted in EX
	logic [XLEN-1:0] sa_zext;

	assign imm_sext = {{(XLEN-16){inst_i.i.imm[15]}}, inst_i.i.imm};
	assign imm_zext = {{(XLEN-16){1'b0}}, inst_i.i.imm};
	assign sa_zext  = {{(XLEN-5){1'b0}}, inst_i.r.sa};

	always_comb begin
		case (src1_sel_i)
			SRC1_SA: opr1_o = sa_zext;
			SRC1_PC: opr1_o = pc_i; // link base, EX adds 8
			default: opr1_o = reg1data_i;
		endcase

		case (src2_sel_i)
			SRC2_IMM_S: opr2_o = imm_sext;
			SRC2_IMM_U: opr2_o = imm_zext;
			SRC2_EIGHT: opr2_o = XLEN'(8);
			default:    opr2_o = reg2data_i;
		endcase

		case (wa_sel_i)
			WA_RT:   waddr_o = inst_i.i.rt;
			WA_31:   waddr_o = REG_AW'(31);
			default: waddr_o = inst_i.r.rd;
		endcase
	end

endmodule

//--- src/id_inst_decode.sv
`timescale 1ns/1ps

module id_inst_decode (
	input  id_pkg::mips_inst_u              inst_i,
	output logic                            ren1_o,
	output logic                            ren2_o,
	output logic [id_pkg::REG_AW-1:0]       reg1addr_o,
	output logic [id_pkg::REG_AW-1:0]       reg2addr_o,
	output logic [id_pkg::AOP_W-1:0]        alu_op_o,
	output logic [id_pkg::MMOP_W-1:0]       mem_op_o,
	output logic [id_pkg::SEL_W-1:0]        src1_sel_o,
	output logic [id_pkg::SEL_W-1:0]        src2_sel_o,
	output logic [id_pkg::SEL_W-1:0]        wa_sel_o,
	output logic                            wren_o,
	output logic                            nofwd_o,
	output logic                            ov_inst_o,
	output logic [id_pkg::BR_W-1:0]         br_kind_o,
	output logic                            exc_sys_o,
	output logic                            exc_brk_o,
	output logic                            exc_ri_o,
	output logic                            exc_eret_o
);
	import id_pkg::*;

	logic [5:0] op, fn;
	logic [4:0] rs, rt, rd;
	logic       special, regimm, sa_z;
	logic i_add, i_addu, i_sub, i_subu, i_slt, i_sltu, i_and, i_or, i_xor, i_nor;
	logic i_sll, i_srl, i_sra, i_sllv, i_srlv, i_srav;
	logic i_addi, i_addiu, i_slti, i_sltiu, i_andi, i_ori, i_xori, i_lui;
	logic i_lb, i_lbu, i_lh, i_lhu, i_lw, i_sb, i_sh, i_sw;
	logic i_beq, i_bne, i_blez, i_bgtz, i_bgez, i_bltz, i_bgezal, i_bltzal;
	logic i_j, i_jal, i_jr, i_jalr, i_syscall, i_break, i_eret;
	logic alu_r, alu_i, shamt, ld, st, cond_br, link, valid;

	assign op      = inst_i.r.opcode;
	assign fn      = inst_i.r.funct;
	assign rs      = inst_i.r.rs;
	assign rt      = inst_i.r.rt;
	assign rd      = inst_i.r.rd;
	assign special = (op == OP_SPECIAL);
	assign regimm  = (op == OP_REGIMM);
	assign sa_z    = (inst_i.r.sa == '0);

	assign i_add   = special & (fn == FN_ADD) & sa_z;
	assign i_addu  = special & (fn == FN_ADDU) & sa_z;
	assign i_sub   = special & (fn == FN_SUB) & sa_z;
	assign i_subu  = special & (fn == FN_SUBU) & sa_z;
	assign i_slt   = special & (fn == FN_SLT) & sa_z;
	assign i_sltu  = special & (fn == FN_SLTU) & sa_z;
	assign i_and   = special & (fn == FN_AND) & sa_z;
	assign i_or    = special & (fn == FN_OR) & sa_z;
	assign i_xor   = special & (fn == FN_XOR) & sa_z;
	assign i_nor   = special & (fn == FN_NOR) & sa_z;
	assign i_sll   = special & (fn == FN_SLL) & (rs == '0);
	assign i_srl   = special & (fn == FN_SRL) & (rs == '0);
	assign i_sra   = special & (fn == FN_SRA) & (rs == '0);
	assign i_sllv  = special & (fn == FN_SLLV) & sa_z;
	assign i_srlv  = special & (fn == FN_SRLV) & sa_z;
	assign i_srav  = special & (fn == FN_SRAV) & sa_z;
	assign i_jr    = special & (fn == FN_JR) & (rt == '0) & (rd == '0) & sa_z;
	assign i_jalr  = special & (fn == FN_JALR) & (rt == '0) & sa_z;
	// code field must be zero, same as eret below
	assign i_syscall = special & (fn == FN_SYSCALL) & ({rs, rt, rd, inst_i.r.sa} == '0);
	assign i_break   = special & (fn == FN_BREAK) & ({rs, rt, rd, inst_i.r.sa} == '0);
	assign i_eret    = (op == OP_COP0) & (fn == FN_ERET) & ({rs, rt, rd, inst_i.r.sa} == 20'h80000);

	assign i_addi  = (op == OP_ADDI);
	assign i_addiu = (op == OP_ADDIU);
	assign i_slti  = (op == OP_SLTI);
	assign i_sltiu = (op == OP_SLTIU);
	assign i_andi  = (op == OP_ANDI);
	assign i_ori   = (op == OP_ORI);
	assign i_xori  = (op == OP_XORI);
	assign i_lui   = (op == OP_LUI) & (rs == '0);
	assign i_lb    = (op == OP_LB);
	assign i_lbu   = (op == OP_LBU);
	assign i_lh    = (op == OP_LH);
	assign i_lhu   = (op == OP_LHU);
	assign i_lw    = (op == OP_LW);
	assign i_sb    = (op == OP_SB);
	assign i_sh    = (op == OP_SH);
	assign i_sw    = (op == OP_SW);

	assign i_beq    = (op == OP_BEQ);
	assign i_bne    = (op == OP_BNE);
	assign i_blez   = (op == OP_BLEZ) & (rt == '0);
	assign i_bgtz   = (op == OP_BGTZ) & (rt == '0);
	assign i_bltz   = regimm & (rt == RT_BLTZ);
	assign i_bgez   = regimm & (rt == RT_BGEZ);
	assign i_bltzal = regimm & (rt == RT_BLTZAL);
	assign i_bgezal = regimm & (rt == RT_BGEZAL);
	assign i_j      = (op == OP_J);
	assign i_jal    = (op == OP_JAL);

	assign shamt   = i_sll | i_srl | i_sra;
	assign alu_r   = i_add | i_addu | i_sub | i_subu | i_slt | i_sltu | i_and | i_or
	               | i_xor | i_nor | shamt | i_sllv | i_srlv | i_srav;
	assign alu_i   = i_addi | i_addiu | i_slti | i_sltiu | i_andi | i_ori | i_xori | i_lui;
	assign ld      = i_lb | i_lbu | i_lh | i_lhu | i_lw;
	assign st      = i_sb | i_sh | i_sw;
	assign cond_br = i_beq | i_bne | i_blez | i_bgtz | i_bgez | i_bltz | i_bgezal | i_bltzal;
	assign link    = i_jal | i_jalr | i_bgezal | i_bltzal; // writes pc+8
	assign valid   = alu_r | alu_i | ld | st | cond_br | i_j | i_jal | i_jr | i_jalr
	               | i_syscall | i_break | i_eret;

	assign alu_op_o[AOP_ADD]  = i_add | i_addu | i_addi | i_addiu | ld | st | link;
	assign alu_op_o[AOP_SUB]  = i_sub | i_subu;
	assign alu_op_o[AOP_SLT]  = i_slt | i_slti;
	assign alu_op_o[AOP_SLTU] = i_sltu | i_sltiu;
	assign alu_op_o[AOP_AND]  = i_and | i_andi;
	assign alu_op_o[AOP_NOR]  = i_nor;
	assign alu_op_o[AOP_OR]   = i_or | i_ori;
	assign alu_op_o[AOP_XOR]  = i_xor | i_xori;
	assign alu_op_o[AOP_SLL]  = i_sll | i_sllv;
	assign alu_op_o[AOP_SRL]  = i_srl | i_srlv;
	assign alu_op_o[AOP_SRA]  = i_sra | i_srav;
	assign alu_op_o[AOP_LUI]  = i_lui;

	assign mem_op_o[MMOP_LB]  = i_lb;
	assign mem_op_o[MMOP_LBU] = i_lbu;
	assign mem_op_o[MMOP_LH]  = i_lh;
	assign mem_op_o[MMOP_LHU] = i_lhu;
	assign mem_op_o[MMOP_LW]  = i_lw;
	assign mem_op_o[MMOP_SB]  = i_sb;
	assign mem_op_o[MMOP_SH]  = i_sh;
	assign mem_op_o[MMOP_SW]  = i_sw;

	assign reg1addr_o = rs;
	assign reg2addr_o = rt;
	assign ren1_o     = (alu_r & ~shamt) | (alu_i & ~i_lui) | ld | st | cond_br | i_jr | i_jalr;
	assign ren2_o     = alu_r | i_beq | i_bne | st;
	assign wren_o     = alu_r | alu_i | ld | link;
	assign nofwd_o    = ld | st;
	assign ov_inst_o  = i_add | i_addi | i_sub;

	assign src1_sel_o = shamt ? SRC1_SA : link ? SRC1_PC : SRC1_REG;
	assign src2_sel_o = (alu_i & ~(i_andi | i_ori | i_xori | i_lui)) | ld | st ? SRC2_IMM_S :
	                    (i_andi | i_ori | i_xori | i_lui) ? SRC2_IMM_U :
	                    link ? SRC2_EIGHT : SRC2_REG;
	assign wa_sel_o   = link ? WA_31 : (alu_i | ld) ? WA_RT : WA_RD;

	assign br_kind_o  = i_beq ? BR_BEQ :
	                    i_bne ? BR_BNE :
	                    (i_bgez | i_bgezal) ? BR_BGEZ :
	                    i_bgtz ? BR_BGTZ :
	                    i_blez ? BR_BLEZ :
	                    (i_bltz | i_bltzal) ? BR_BLTZ :
	                    (i_j | i_jal) ? BR_J :
	                    (i_jr | i_jalr) ? BR_JR : BR_NONE;

	assign exc_sys_o  = i_syscall;
	assign exc_brk_o  = i_break;
	assign exc_ri_o   = ~valid;
	assign exc_eret_o = i_eret;

endmodule

//--- src/id_pkg.sv
package id_pkg;

	localparam int XLEN   = 32;
	localparam int REG_AW = 5;

	// primary opcodes
	localparam logic [5:0] OP_SPECIAL = 6'h00;
	localparam logic [5:0] OP_REGIMM  = 6'h01;
	localparam logic [5:0] OP_J       = 6'h02;
	localparam logic [5:0] OP_JAL     = 6'h03;
	localparam logic [5:0] OP_BEQ     = 6'h04;
	localparam logic [5:0] OP_BNE     = 6'h05;
	localparam logic [5:0] OP_BLEZ    = 6'h06;
	localparam logic [5:0] OP_BGTZ    = 6'h07;
	localparam logic [5:0] OP_ADDI    = 6'h08;
	localparam logic [5:0] OP_ADDIU   = 6'h09;
	localparam logic [5:0] OP_SLTI    = 6'h0a;
	localparam logic [5:0] OP_SLTIU   = 6'h0b;
	localparam logic [5:0] OP_ANDI    = 6'h0c;
	localparam logic [5:0] OP_ORI     = 6'h0d;
	localparam logic [5:0] OP_XORI    = 6'h0e;
	localparam logic [5:0] OP_LUI     = 6'h0f;
	localparam logic [5:0] OP_COP0    = 6'h10;
	localparam logic [5:0] OP_LB      = 6'h20;
	localparam logic [5:0] OP_LH      = 6'h21;
	localparam logic [5:0] OP_LW      = 6'h23;
	localparam logic [5:0] OP_LBU     = 6'h24;
	localparam logic [5:0] OP_LHU     = 6'h25;
	localparam logic [5:0] OP_SB      = 6'h28;
	localparam logic [5:0] OP_SH      = 6'h29;
	localparam logic [5:0] OP_SW      = 6'h2b;

	// function field of special and cop0
	localparam logic [5:0] FN_SLL     = 6'h00;
	localparam logic [5:0] FN_SRL     = 6'h02;
	localparam logic [5:0] FN_SRA     = 6'h03;
	localparam logic [5:0] FN_SLLV    = 6'h04;
	localparam logic [5:0] FN_SRLV    = 6'h06;
	localparam logic [5:0] FN_SRAV    = 6'h07;
	localparam logic [5:0] FN_JR      = 6'h08;
	localparam logic [5:0] FN_JALR    = 6'h09;
	localparam logic [5:0] FN_SYSCALL = 6'h0c;
	localparam logic [5:0] FN_BREAK   = 6'h0d;
	localparam logic [5:0] FN_ERET    = 6'h18;
	localparam logic [5:0] FN_ADD     = 6'h20;
	localparam logic [5:0] FN_ADDU    = 6'h21;
	localparam logic [5:0] FN_SUB     = 6'h22;
	localparam logic [5:0] FN_SUBU    = 6'h23;
	localparam logic [5:0] FN_AND     = 6'h24;
	localparam logic [5:0] FN_OR      = 6'h25;
	localparam logic [5:0] FN_XOR     = 6'h26;
	localparam logic [5:0] FN_NOR     = 6'h27;
	localparam logic [5:0] FN_SLT     = 6'h2a;
	localparam logic [5:0] FN_SLTU    = 6'h2b;

	// rt field of regimm
	localparam logic [4:0] RT_BLTZ    = 5'h00;
	localparam logic [4:0] RT_BGEZ    = 5'h01;
	localparam logic [4:0] RT_BLTZAL  = 5'h10;
	localparam logic [4:0] RT_BGEZAL  = 5'h11;

	localparam int AOP_W = 12;
	localparam int AOP_ADD  = 0;
	localparam int AOP_SUB  = 1;
	localparam int AOP_SLT  = 2;
	localparam int AOP_SLTU = 3;
	localparam int AOP_AND  = 4;
	localparam int AOP_NOR  = 5;
	localparam int AOP_OR   = 6;
	localparam int AOP_XOR  = 7;
	localparam int AOP_SLL  = 8;
	localparam int AOP_SRL  = 9;
	localparam int AOP_SRA  = 10;
	localparam int AOP_LUI  = 11;

	localparam int MMOP_W = 8;
	localparam int MMOP_LB  = 0;
	localparam int MMOP_LBU = 1;
	localparam int MMOP_LH  = 2;
	localparam int MMOP_LHU = 3;
	localparam int MMOP_LW  = 4;
	localparam int MMOP_SB  = 5;
	localparam int MMOP_SH  = 6;
	localparam int MMOP_SW  = 7;

	localparam int EXC_W    = 9; // bits 4..1 come from fetch
	localparam int EXC_SYS  = 5;
	localparam int EXC_BRK  = 6;
	localparam int EXC_RI   = 7;
	localparam int EXC_ERET = 8;

	localparam int SEL_W = 2;
	localparam logic [SEL_W-1:0] SRC1_REG   = 2'd0;
	localparam logic [SEL_W-1:0] SRC1_SA    = 2'd1;
	localparam logic [SEL_W-1:0] SRC1_PC    = 2'd2;
	localparam logic [SEL_W-1:0] SRC2_REG   = 2'd0;
	localparam logic [SEL_W-1:0] SRC2_IMM_S = 2'd1;
	localparam logic [SEL_W-1:0] SRC2_IMM_U = 2'd2;
	localparam logic [SEL_W-1:0] SRC2_EIGHT = 2'd3;
	localparam logic [SEL_W-1:0] WA_RD      = 2'd0;
	localparam logic [SEL_W-1:0] WA_RT      = 2'd1;
	localparam logic [SEL_W-1:0] WA_31      = 2'd2;

	// link forms share the kind of the plain branch
	localparam int BR_W = 4;
	localparam logic [BR_W-1:0] BR_NONE = 4'd0;
	localparam logic [BR_W-1:0] BR_BEQ  = 4'd1;
	localparam logic [BR_W-1:0] BR_BNE  = 4'd2;
	localparam logic [BR_W-1:0] BR_BGEZ = 4'd3;
	localparam logic [BR_W-1:0] BR_BGTZ = 4'd4;
	localparam logic [BR_W-1:0] BR_BLEZ = 4'd5;
	localparam logic [BR_W-1:0] BR_BLTZ = 4'd6;
	localparam logic [BR_W-1:0] BR_J    = 4'd7;
	localparam logic [BR_W-1:0] BR_JR   = 4'd8;

	localparam int WREN_W = 4;

	typedef union packed {
		struct packed {
			logic [5:0] opcode;
			logic [4:0] rs;
			logic [4:0] rt;
			logic [4:0] rd;
			logic [4:0] sa;
			logic [5:0] funct;
		} r;
		struct packed {
			logic [5:0]  opcode;
			logic [4:0]  rs;
			logic [4:0]  rt;
			logic [15:0] imm;
		} i;
		struct packed {
			logic [5:0]  opcode;
			logic [25:0] target;
		} j;
	} mips_inst_u;

endpackage
